/* design/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // data and instruction width
    localparam int XLEN = 32;

    // width of one compressed parcel
    localparam int HLEN = 16;

    typedef logic [HLEN-1:0] half_t;
    typedef logic [XLEN-1:0] word_t;

    // low opcode bits 11 mark a 32-bit instruction, anything else is compressed
    localparam logic [1:0] OPC_FULL = 2'b11;

    // true when the parcel opens a 32-bit instruction
    function automatic logic is_full(half_t parcel);
        return (parcel[1:0] == OPC_FULL);
    endfunction

endpackage

`default_nettype wire

/* design/rv_fetch_pkg.sv */
`default_nettype none

package rv_fetch_pkg;

    // memory port carries word addresses, byte bits 1:0 are implied zero
    localparam int WADDR_BITS = rv_isa_pkg::XLEN - 2;

    // read request to the instruction memory
    typedef struct packed {
        logic                  valid;
        logic [WADDR_BITS-1:0] addr;
    } mem_req_t;

    // one complete instruction for decode
    typedef struct packed {
        rv_isa_pkg::word_t           instr;
        logic [rv_isa_pkg::XLEN-1:0] pc;
        logic [rv_isa_pkg::XLEN-1:0] pc_next;
        // 16-bit encoding, zero-extended into instr
        logic                        compressed;
    } fetch_out_t;

endpackage

`default_nettype wire

/* design/rv_fetch_buf.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_fetch_buf
#(
    parameter type entry_t    = rv_isa_pkg::half_t,
    parameter int  IADDR_BITS = 16,
    parameter int  DEPTH_BITS = 2
)
(
    input  wire                             i_clk,
    input  wire                             i_reset,
    input  wire                             i_flush,
    input  wire  [IADDR_BITS-1:1]           i_pc,
    input  wire  entry_t                    i_data_lo,
    input  wire  entry_t                    i_data_hi,
    input  wire                             i_push_single,
    input  wire                             i_push_double,
    input  wire                             i_pop,
    output rv_fetch_pkg::fetch_out_t        o_out,
    output logic                            o_not_empty,
    output logic                            o_not_full
);

    localparam int DEPTH = 1 << DEPTH_BITS;
    // halfword entries may hold compressed code, word entries one instruction each
    localparam bit HALF_ENTRIES = ($bits(entry_t) == rv_isa_pkg::HLEN);

    entry_t                 mem [DEPTH];
    logic [DEPTH_BITS-1:0]  rd_ptr;
    logic [DEPTH_BITS-1:0]  rd_ptr_inc;
    logic [DEPTH_BITS-1:0]  wr_ptr;
    logic [DEPTH_BITS-1:0]  wr_ptr_inc;
    logic [DEPTH_BITS:0]    count;
    logic [IADDR_BITS-1:1]  head_pc;
    logic [IADDR_BITS-1:1]  head_pc_next;
    rv_isa_pkg::word_t      head_word;
    rv_isa_pkg::word_t      second_word;
    logic                   two_entries;
    logic                   len4;
    logic [1:0]             push_n;
    logic [1:0]             pop_n;
    logic                   pop;

    assign rd_ptr_inc  = rd_ptr + 1'b1;
    assign wr_ptr_inc  = wr_ptr + 1'b1;
    assign head_word   = rv_isa_pkg::word_t'(mem[rd_ptr]);
    assign second_word = rv_isa_pkg::word_t'(mem[rd_ptr_inc]);

    // length of the head instruction in entries
    assign two_entries = HALF_ENTRIES &&
                         rv_isa_pkg::is_full(head_word[rv_isa_pkg::HLEN-1:0]);
    assign len4        = !HALF_ENTRIES || two_entries;
    assign pop_n       = two_entries ? 2'd2 : 2'd1;

    // only a whole instruction counts as available
    assign o_not_empty = (count != '0) && (count >= (DEPTH_BITS+1)'(pop_n));
    // room for a double push
    assign o_not_full  = (count <= (DEPTH_BITS+1)'(DEPTH - 2));

    assign pop    = i_pop & o_not_empty;
    assign push_n = i_push_double ? 2'd2 : {1'b0, i_push_single};

    assign head_pc_next = head_pc + (len4 ? (IADDR_BITS-1)'(2) : (IADDR_BITS-1)'(1));

    always_comb
    begin
        // a compressed parcel is already zero-extended in head_word
        o_out.instr      = two_entries ?
                           {second_word[rv_isa_pkg::HLEN-1:0], head_word[rv_isa_pkg::HLEN-1:0]} :
                           head_word;
        o_out.pc         = rv_isa_pkg::word_t'({head_pc, 1'b0});
        o_out.pc_next    = rv_isa_pkg::word_t'({head_pc_next, 1'b0});
        o_out.compressed = !len4;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
        begin
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            count   <= '0;
            // restart the head at the new fetch address
            head_pc <= i_pc;
        end
        else
        begin
            if (pop)
            begin
                rd_ptr  <= rd_ptr + DEPTH_BITS'(pop_n);
                head_pc <= head_pc_next;
            end
            wr_ptr <= wr_ptr + DEPTH_BITS'(push_n);
            count  <= count + (DEPTH_BITS+1)'(push_n) -
                      (pop ? (DEPTH_BITS+1)'(pop_n) : '0);
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_push_double)
        begin
            mem[wr_ptr]     <= i_data_lo;
            mem[wr_ptr_inc] <= i_data_hi;
        end
        else if (i_push_single)
        begin
            // single parcel is the upper half of the word
            mem[wr_ptr] <= i_data_hi;
        end
    end

endmodule

`default_nettype wire

/* design/rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_fetch
#(
    parameter logic [31:0] RESET_ADDR     = 32'h0000_0000,
    parameter int          IADDR_BITS     = 16,
    parameter int          BUF_DEPTH_BITS = 2,
    parameter bit          EXT_C          = 1'b1
)
(
    input  wire                          i_clk,
    input  wire                          i_reset,
    input  wire                          i_stall,
    input  wire                          i_pc_select,
    input  wire  [IADDR_BITS-1:1]        i_pc_target,
    input  wire                          i_ebreak,
    input  wire  [IADDR_BITS-1:1]        i_pc_trap,
    input  wire                          i_ack,
    input  wire  rv_isa_pkg::word_t      i_instruction,
    output logic                         o_cyc,
    output logic [IADDR_BITS-1:1]        o_addr,
    output logic                         o_pc_change,
    output rv_fetch_pkg::fetch_out_t     o_fetch,
    output logic                         o_ready
);

    logic [IADDR_BITS-1:1]  pc;
    logic [IADDR_BITS-1:1]  pc_next;
    logic [IADDR_BITS-1:1]  pc_incr;
    logic                   change_pc;
    logic                   move_pc;
    logic                   half_align;
    logic                   push_next;
    logic                   push_single;
    logic                   push_double;
    rv_isa_pkg::word_t      instr_q;
    logic                   buf_pop;
    logic                   not_empty;
    logic                   not_full;

    assign change_pc  = i_ebreak | i_pc_select;
    assign move_pc    = i_ack & not_full;
    assign half_align = pc[1] & EXT_C;
    // from an odd halfword only the upper parcel of the word is left
    assign pc_incr    = half_align ? (IADDR_BITS-1)'(1) : (IADDR_BITS-1)'(2);

    // trap wins over branch target
    always_comb
    begin
        if (i_reset)
            pc_next = RESET_ADDR[IADDR_BITS-1:1];
        else if (i_ebreak)
            pc_next = i_pc_trap;
        else if (i_pc_select)
            pc_next = i_pc_target;
        else
            pc_next = pc + pc_incr;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset || change_pc || move_pc)
            pc <= pc_next;
    end

    // data arriving with a redirect belongs to the old path
    assign push_next = move_pc & ~change_pc;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            push_single <= 1'b0;
            push_double <= 1'b0;
        end
        else
        begin
            push_single <= push_next & (half_align | !EXT_C);
            push_double <= push_next & EXT_C & !half_align;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (push_next)
            instr_q <= i_instruction;
    end

    assign buf_pop = ~i_stall & not_empty;

    generate
        if (EXT_C)
        begin : g_half
            rv_fetch_buf
            #(
                .entry_t        (rv_isa_pkg::half_t),
                .IADDR_BITS     (IADDR_BITS),
                .DEPTH_BITS     (BUF_DEPTH_BITS)
            )
            u_buf
            (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_flush        (change_pc),
                .i_pc           (pc_next),
                .i_data_lo      (instr_q[15:0]),
                .i_data_hi      (instr_q[31:16]),
                .i_push_single  (push_single),
                .i_push_double  (push_double),
                .i_pop          (buf_pop),
                .o_out          (o_fetch),
                .o_not_empty    (not_empty),
                .o_not_full     (not_full)
            );
        end
        else
        begin : g_word
            // one entry per word, only single pushes occur
            rv_fetch_buf
            #(
                .entry_t        (rv_isa_pkg::word_t),
                .IADDR_BITS     (IADDR_BITS),
                .DEPTH_BITS     (BUF_DEPTH_BITS)
            )
            u_buf
            (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_flush        (change_pc),
                .i_pc           (pc_next),
                .i_data_lo      (instr_q),
                .i_data_hi      (instr_q),
                .i_push_single  (push_single),
                .i_push_double  (push_double),
                .i_pop          (buf_pop),
                .o_out          (o_fetch),
                .o_not_empty    (not_empty),
                .o_not_full     (not_full)
            );
        end
    endgenerate

    assign o_pc_change = change_pc;
    // keep requesting while the buffer has room
    assign o_cyc       = not_full;
    assign o_addr      = pc;
    assign o_ready     = not_empty;

endmodule

`default_nettype wire

/* design/rv_ibus_port.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_ibus_port
#(
    parameter int IADDR_BITS = 16
)
(
    input  wire                          i_clk,
    input  wire                          i_reset,
    input  wire                          i_cyc,
    input  wire  [IADDR_BITS-1:1]        i_addr,
    input  wire                          i_flush,
    input  wire  rv_isa_pkg::word_t      i_mem_rdata,
    output rv_fetch_pkg::mem_req_t       o_mem_req,
    output logic                         o_ack,
    output rv_isa_pkg::word_t            o_data
);

    logic               pending;
    logic               cancel;
    logic               req_valid;
    rv_isa_pkg::word_t  byte_addr;

    // a single read in flight at any time
    assign req_valid = i_cyc & ~pending;
    assign byte_addr = rv_isa_pkg::word_t'({i_addr, 1'b0});

    always_comb
    begin
        o_mem_req.valid = req_valid;
        o_mem_req.addr  = byte_addr[rv_isa_pkg::XLEN-1:2];
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            // port stays busy through reset, so no request goes out
            pending <= 1'b1;
            cancel  <= 1'b1;
        end
        else
        begin
            pending <= req_valid;
            // request issued in a redirect cycle used the old PC
            cancel  <= req_valid & i_flush;
        end
    end

    // memory answers one cycle after the request
    assign o_ack  = pending & ~cancel & ~i_flush;
    assign o_data = i_mem_rdata;

endmodule

`default_nettype wire

/* design/rv_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_fetch_top
#(
    parameter logic [31:0] RESET_ADDR     = 32'h0000_0000,
    parameter int          IADDR_BITS     = 16,
    parameter int          BUF_DEPTH_BITS = 2,
    parameter bit          EXT_C          = 1'b1
)
(
    input  wire                          i_clk,
    input  wire                          i_reset,
    output rv_fetch_pkg::mem_req_t       o_mem_req,
    input  wire  rv_isa_pkg::word_t      i_mem_rdata,
    input  wire                          i_stall,
    input  wire                          i_pc_select,
    input  wire  [IADDR_BITS-1:1]        i_pc_target,
    input  wire                          i_ebreak,
    input  wire  [IADDR_BITS-1:1]        i_pc_trap,
    output rv_fetch_pkg::fetch_out_t     o_fetch,
    output logic                         o_ready,
    output logic                         o_pc_change
);

    logic                   cyc;
    logic [IADDR_BITS-1:1]  addr;
    logic                   ack;
    rv_isa_pkg::word_t      data;

    rv_fetch
    #(
        .RESET_ADDR     (RESET_ADDR),
        .IADDR_BITS     (IADDR_BITS),
        .BUF_DEPTH_BITS (BUF_DEPTH_BITS),
        .EXT_C          (EXT_C)
    )
    u_fetch
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_stall        (i_stall),
        .i_pc_select    (i_pc_select),
        .i_pc_target    (i_pc_target),
        .i_ebreak       (i_ebreak),
        .i_pc_trap      (i_pc_trap),
        .i_ack          (ack),
        .i_instruction  (data),
        .o_cyc          (cyc),
        .o_addr         (addr),
        .o_pc_change    (o_pc_change),
        .o_fetch        (o_fetch),
        .o_ready        (o_ready)
    );

    // a redirect drops the read in flight
    rv_ibus_port
    #(
        .IADDR_BITS     (IADDR_BITS)
    )
    u_ibus
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_cyc          (cyc),
        .i_addr         (addr),
        .i_flush        (o_pc_change),
        .i_mem_rdata    (i_mem_rdata),
        .o_mem_req      (o_mem_req),
        .o_ack          (ack),
        .o_data         (data)
    );

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
#(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 5
)
(
    output logic o_clk,
    output logic o_reset
);

    initial
    begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    // release reset shortly after an edge, like the other inputs
    initial
    begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #2;
        o_reset = 1'b0;
    end

endmodule

`default_nettype wire

/* bench/tb_fetch_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_sva
(
    input wire                          i_clk,
    input wire                          i_reset,
    input wire                          i_stall,
    input wire                          i_ready,
    input wire                          i_pc_change,
    input wire                          i_req_valid,
    input wire rv_fetch_pkg::fetch_out_t i_fetch
);

    int   n_failures = 0;
    logic reset_q;

    always_ff @(posedge i_clk)
    begin
        reset_q <= i_reset;
    end

    // decode sees nothing while reset is held
    a_ready_in_reset: assert property (@(posedge i_clk) (i_reset && reset_q) |-> !i_ready)
    else
    begin
        n_failures++;
        $error("o_ready high during reset");
    end

    // a stalled instruction holds until decode takes it
    a_stall_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_ready && i_stall && !i_pc_change) |=> (i_ready && $stable(i_fetch)))
    else
    begin
        n_failures++;
        $error("o_fetch changed while stalled");
    end

    // only one read in flight, so never back to back
    a_req_spacing: assert property (@(posedge i_clk) disable iff (i_reset)
        i_req_valid |=> !i_req_valid)
    else
    begin
        n_failures++;
        $error("memory request valid in two consecutive cycles");
    end

endmodule

bind rv_fetch_top tb_fetch_sva u_sva
(
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_stall     (i_stall),
    .i_ready     (o_ready),
    .i_pc_change (o_pc_change),
    .i_req_valid (o_mem_req.valid),
    .i_fetch     (o_fetch)
);

`default_nettype wire

/* bench/tb_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch;

    localparam logic [31:0] RESET_ADDR = 32'h0000_0010;
    localparam int          IADDR_BITS = 16;

    logic                       i_clk;
    logic                       i_reset;
    logic                       i_stall;
    logic                       i_pc_select;
    logic [IADDR_BITS-1:1]      i_pc_target;
    logic                       i_ebreak;
    logic [IADDR_BITS-1:1]      i_pc_trap;
    rv_isa_pkg::word_t          i_mem_rdata;
    rv_fetch_pkg::mem_req_t     mem_req;
    rv_fetch_pkg::mem_req_t     req_q;
    rv_fetch_pkg::fetch_out_t   fetch;
    logic                       ready;
    logic                       pc_change;

    rv_isa_pkg::word_t  imem [256];
    logic [31:0]        lfsr = 32'd99784;
    logic               stall_en = 1'b0;
    logic [31:0]        exp_pc = RESET_ADDR;
    logic [31:0]        first_pc;
    logic [31:0]        last_pc;
    int                 n_delivered = 0;
    int                 n_straddle = 0;
    int                 n_errors = 0;

    tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(5)) u_clk (.o_clk(i_clk), .o_reset(i_reset));

    rv_fetch_top
    #(
        .RESET_ADDR     (RESET_ADDR),
        .IADDR_BITS     (IADDR_BITS),
        .BUF_DEPTH_BITS (2),
        .EXT_C          (1'b1)
    )
    dut
    (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .o_mem_req   (mem_req),
        .i_mem_rdata (i_mem_rdata),
        .i_stall     (i_stall),
        .i_pc_select (i_pc_select),
        .i_pc_target (i_pc_target),
        .i_ebreak    (i_ebreak),
        .i_pc_trap   (i_pc_trap),
        .o_fetch     (fetch),
        .o_ready     (ready),
        .o_pc_change (pc_change)
    );

    // galois lfsr, one step per bit
    function automatic logic next_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
            r[i] = next_bit();
        return r;
    endfunction

    // memory aliases every 1 KiB
    function automatic rv_isa_pkg::half_t half_at(input logic [31:0] addr);
        rv_isa_pkg::word_t w;
        w = imem[addr[9:2]];
        return addr[1] ? w[31:16] : w[15:0];
    endfunction

    function automatic rv_fetch_pkg::fetch_out_t ref_fetch(input logic [31:0] pc);
        rv_fetch_pkg::fetch_out_t r;
        rv_isa_pkg::half_t        lo;
        lo   = half_at(pc);
        r.pc = pc;
        if (lo[1:0] == rv_isa_pkg::OPC_FULL)
        begin
            r.instr      = {half_at(pc + 32'd2), lo};
            r.pc_next    = pc + 32'd4;
            r.compressed = 1'b0;
        end
        else
        begin
            r.instr      = {16'h0000, lo};
            r.pc_next    = pc + 32'd2;
            r.compressed = 1'b1;
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            n_errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic wait_delivered(input int count, input int max_cycles);
        int cycles;
        cycles = 0;
        while (n_delivered < count && cycles < max_cycles)
        begin
            @(posedge i_clk);
            cycles++;
        end
        if (n_delivered < count)
        begin
            $display("timeout: instruction %0d at pc %h never arrived", count, exp_pc);
            $display("Checks failed");
            $fatal(1, "fetch timeout");
        end
    endtask

    // one-cycle redirect pulse
    task automatic redirect(input logic [31:0] target, input logic [31:0] trap,
                            input logic with_ebreak);
        @(posedge i_clk);
        #2;
        i_pc_select = 1'b1;
        i_pc_target = target[IADDR_BITS-1:1];
        i_ebreak    = with_ebreak;
        i_pc_trap   = trap[IADDR_BITS-1:1];
        @(posedge i_clk);
        #2;
        i_pc_select = 1'b0;
        i_ebreak    = 1'b0;
    endtask

    // memory answers the request seen in the previous cycle
    always @(negedge i_clk)
        req_q <= mem_req;

    always @(posedge i_clk)
    begin
        #2;
        if (req_q.valid)
            i_mem_rdata = imem[req_q.addr[7:0]];
        i_stall = stall_en ? next_bit() : 1'b0;
    end

    always @(negedge i_clk)
    begin : compare
        rv_fetch_pkg::fetch_out_t want;
        if (!i_reset)
        begin
            check_value("pc_change", 32'(i_pc_select | i_ebreak), 32'(pc_change));
            check_value("assertions", 32'd0, 32'(dut.u_sva.n_failures));
            if (i_ebreak)
                exp_pc = 32'({i_pc_trap, 1'b0});
            else if (i_pc_select)
                exp_pc = 32'({i_pc_target, 1'b0});
            else if (ready && !i_stall)
            begin
                want = ref_fetch(exp_pc);
                check_value("instr", want.instr, fetch.instr);
                check_value("pc", want.pc, fetch.pc);
                check_value("pc_next", want.pc_next, fetch.pc_next);
                check_value("compressed", 32'(want.compressed), 32'(fetch.compressed));
                if (n_delivered == 0)
                    first_pc = fetch.pc;
                if (!want.compressed && want.pc[1])
                    n_straddle++;
                last_pc = fetch.pc;
                n_delivered++;
                exp_pc = want.pc_next;
            end
        end
    end

    initial
    begin : run_tests
        int base;
        int cycles;
        i_stall     = 1'b0;
        i_pc_select = 1'b0;
        i_pc_target = '0;
        i_ebreak    = 1'b0;
        i_pc_trap   = '0;
        i_mem_rdata = '0;
        for (int i = 0; i < 256; i++)
            imem[i] = rand_bits(32);

        // first instruction after reset, then a long sequential stream
        wait_delivered(1, 60);
        check_value("reset_pc", RESET_ADDR, first_pc);
        wait_delivered(200, 2000);
        check_value("straddle_seen", 32'd1, 32'(n_straddle > 0));

        // back-pressure from decode
        stall_en = 1'b1;
        wait_delivered(350, 4000);

        // branches to odd and even halfword targets
        redirect(32'h0000_0102, 32'h0, 1'b0);
        base = n_delivered;
        wait_delivered(base + 1, 200);
        check_value("branch_odd", 32'h0000_0102, last_pc);
        wait_delivered(base + 20, 400);
        redirect(32'h0000_03fe, 32'h0, 1'b0);
        base = n_delivered;
        wait_delivered(base + 1, 200);
        check_value("branch_wrap", 32'h0000_03fe, last_pc);
        wait_delivered(base + 20, 400);
        redirect(32'h0000_0200, 32'h0, 1'b0);
        base = n_delivered;
        wait_delivered(base + 1, 200);
        check_value("branch_even", 32'h0000_0200, last_pc);
        wait_delivered(base + 20, 400);

        // trap wins over a branch in the same cycle
        redirect(32'h0000_0300, 32'h0000_0080, 1'b1);
        base = n_delivered;
        wait_delivered(base + 1, 200);
        check_value("ebreak", 32'h0000_0080, last_pc);
        wait_delivered(base + 20, 400);

        // redirect while a read is in flight
        cycles = 0;
        @(negedge i_clk);
        while (!mem_req.valid && cycles < 100)
        begin
            @(negedge i_clk);
            cycles++;
        end
        if (!mem_req.valid)
        begin
            $display("timeout: no memory request seen before the pending redirect");
            $display("Checks failed");
            $fatal(1, "request timeout");
        end
        redirect(32'h0000_0156, 32'h0, 1'b0);
        base = n_delivered;
        wait_delivered(base + 1, 200);
        check_value("pending_redirect", 32'h0000_0156, last_pc);
        wait_delivered(base + 30, 600);

        if (n_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
design/rv_isa_pkg.sv
design/rv_fetch_pkg.sv
design/rv_fetch_buf.sv
design/rv_fetch.sv
design/rv_ibus_port.sv
design/rv_fetch_top.sv
bench/tb_clock_gen.sv
bench/tb_fetch_sva.sv
bench/tb_fetch.sv
